/* Bender.yml */
package:
  name: uart_axil

sources:
  - uart_pkg.sv
  - sync_fifo.sv
  - uart_tx.sv
  - uart_rx.sv
  - axil_bridge.sv
  - uart_axil.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - uart_axil_properties.sv
      - tb_uart_axil.sv

/* axil_bridge.sv */
`timescale 1ns/1ps

module axil_bridge (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            awvalid_i,
	output logic                            awready_o,
	input  logic [uart_pkg::ADDR_WIDTH-1:0] awaddr_i,
	input  logic                            wvalid_i,
	output logic                            wready_o,
	input  logic [31:0]                     wdata_i,
	input  logic [3:0]                      wstrb_i,
	output logic                            bvalid_o,
	input  logic                            bready_i,
	output logic [1:0]                      bresp_o,
	input  logic                            arvalid_i,
	output logic                            arready_o,
	input  logic [uart_pkg::ADDR_WIDTH-1:0] araddr_i,
	output logic                            rvalid_o,
	input  logic                            rready_i,
	output logic [31:0]                     rdata_o,
	output logic [1:0]                      rresp_o,
	output logic                            req_valid_o,
	output logic                            req_wr_o,
	output logic [uart_pkg::ADDR_WIDTH-1:0] req_addr_o,
	output logic [31:0]                     req_wdata_o,
	output logic [3:0]                      req_be_o,
	input  logic                            rsp_done_i,
	input  logic [31:0]                     rsp_rdata_i,
	input  logic                            rsp_err_i
);
	import uart_pkg::*;

	bridge_state_e state;
	logic [1:0]    resp;

	assign resp = rsp_err_i ? RESP_SLVERR : RESP_OKAY;

	// request payload and response data
	always_ff @(posedge clk) begin
		if (state == IDLE && awready_o) begin
			req_wr_o    <= 1'b1;
			req_addr_o  <= awaddr_i;
			req_wdata_o <= wdata_i;
			req_be_o    <= wstrb_i;
		end else if (state == IDLE && arready_o) begin
			req_wr_o    <= 1'b0;
			req_addr_o  <= araddr_i;
			req_wdata_o <= '0;
			req_be_o    <= '0;
		end
		if (state == REQ && rsp_done_i) begin
			rdata_o <= rsp_rdata_i;
			bresp_o <= resp;
			rresp_o <= resp;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state       <= IDLE;
			awready_o   <= 1'b0;
			wready_o    <= 1'b0;
			arready_o   <= 1'b0;
			bvalid_o    <= 1'b0;
			rvalid_o    <= 1'b0;
			req_valid_o <= 1'b0;
		end else begin
			req_valid_o <= 1'b0;
			case (state)
				IDLE: begin
					if (awready_o) begin
						// aw and w handshake this cycle
						awready_o   <= 1'b0;
						wready_o    <= 1'b0;
						req_valid_o <= 1'b1;
						state       <= REQ;
					end else if (arready_o) begin
						arready_o   <= 1'b0;
						req_valid_o <= 1'b1;
						state       <= REQ;
					end else if (awvalid_i && wvalid_i) begin
						// writes win over reads
						awready_o <= 1'b1;
						wready_o  <= 1'b1;
					end else if (arvalid_i) begin
						arready_o <= 1'b1;
					end
				end
				REQ: begin
					if (rsp_done_i) begin
						bvalid_o <= req_wr_o;
						rvalid_o <= !req_wr_o;
						state    <= RESP;
					end
				end
				RESP: begin
					if ((bvalid_o && bready_i) || (rvalid_o && rready_i)) begin
						bvalid_o <= 1'b0;
						rvalid_o <= 1'b0;
						state    <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* list.f */
uart_pkg.sv
sync_fifo.sv
uart_tx.sv
uart_rx.sv
axil_bridge.sv
uart_axil.sv
tb_clock_gen.sv
uart_axil_properties.sv
tb_uart_axil.sv

/* sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
	parameter int DEPTH_LOG2 = 4
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  wr_en_i,
	input  logic [7:0]            wr_data_i,
	input  logic                  rd_en_i,
	output logic [7:0]            rd_data_o,
	output logic                  empty_o,
	output logic                  full_o,
	output logic [DEPTH_LOG2:0]   count_o
);

	localparam int DEPTH = 2 ** DEPTH_LOG2;

	logic [7:0]            mem [DEPTH];
	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;
	logic                  do_wr;
	logic                  do_rd;

	assign empty_o = (count_o == '0);
	assign full_o  = (count_o == (DEPTH_LOG2 + 1)'(DEPTH));

	// overflow and underflow are dropped here
	assign do_wr = wr_en_i && !full_o;
	assign do_rd = rd_en_i && !empty_o;

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data_i;
		end
		// read data shows up one cycle after rd_en
		if (do_rd) begin
			rd_data_o <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count_o <= count_o + 1'b1;
				2'b01:   count_o <= count_o - 1'b1;
				default: count_o <= count_o;
			endcase
		end
	end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter real PERIOD_NS = 4.0
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD_NS / 2.0) clk_o = ~clk_o;
		end
	end

endmodule

/* tb_uart_axil.sv */
`timescale 1ns/1ps

module tb_uart_axil;
	import uart_pkg::*;

	localparam real CLK_FREQ = 250e6;
	localparam real UART_BPS = 15.625e6;
	localparam int BIT_CYCLES = 16;
	localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
	localparam int TX_DEPTH = 1 << TX_FIFO_AW;
	localparam int RX_DEPTH = 1 << RX_FIFO_AW;
	// serial frames over all tests in both directions
	localparam int TEST_FRAMES = 20 + 4 + 6 + 2 + (TX_DEPTH + 1);
	localparam int CYCLE_LIMIT = 4 * TEST_FRAMES * FRAME_CYCLES;

	logic        clk;
	logic        rst;
	logic        awvalid;
	logic        awready;
	logic [3:0]  awaddr;
	logic        wvalid;
	logic        wready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        bvalid;
	logic        bready;
	logic [1:0]  bresp;
	logic        arvalid;
	logic        arready;
	logic [3:0]  araddr;
	logic        rvalid;
	logic        rready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        uart_rx;
	logic        uart_cts;
	logic        uart_tx;
	logic        uart_rts;

	integer      seed = 32'hea1d_da3a;
	int          err_count = 0;
	int          test_count = 0;
	int          test_fail = 0;
	int          test_err_start = 0;
	int          cycle_cnt = 0;
	logic        bp_enable = 1'b1;
	logic        overrun_flag = 1'b0;
	logic        frame_flag = 1'b0;
	logic [7:0]  tx_expect[$];
	logic [7:0]  tx_seen[$];
	logic [7:0]  rx_model[$];

	tb_clock_gen #(.PERIOD_NS(4.0)) u_clk_gen (.clk_o(clk));

	uart_axil #(
		.CLK_FREQ (CLK_FREQ),
		.UART_BPS (UART_BPS)
	) uut (
		.clk        (clk),
		.rst        (rst),
		.awvalid_i  (awvalid),
		.awready_o  (awready),
		.awaddr_i   (awaddr),
		.wvalid_i   (wvalid),
		.wready_o   (wready),
		.wdata_i    (wdata),
		.wstrb_i    (wstrb),
		.bvalid_o   (bvalid),
		.bready_i   (bready),
		.bresp_o    (bresp),
		.arvalid_i  (arvalid),
		.arready_o  (arready),
		.araddr_i   (araddr),
		.rvalid_o   (rvalid),
		.rready_i   (rready),
		.rdata_o    (rdata),
		.rresp_o    (rresp),
		.uart_rx_i  (uart_rx),
		.uart_cts_i (uart_cts),
		.uart_tx_o  (uart_tx),
		.uart_rts_o (uart_rts)
	);

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			err_count++;
		end
	endtask

	function automatic int total_errors();
		return err_count + uut.u_props.fail_cnt;
	endfunction

	function automatic logic [31:0] expected_status();
		logic [31:0] s;
		s = '0;
		// status is only read with the transmitter drained
		s[STAT_TX_EMPTY]   = 1'b1;
		s[STAT_RX_VALID]   = (rx_model.size() != 0);
		s[STAT_RX_OVERRUN] = overrun_flag;
		s[STAT_RX_FRAME]   = frame_flag;
		return s;
	endfunction

	task automatic take_response(input logic is_write);
		int delay;
		do @(negedge clk); while (!(is_write ? bvalid : rvalid));
		delay = bp_enable ? ($unsigned($random(seed)) % 4) : 0;
		repeat (delay) begin
			@(posedge clk);
			@(negedge clk);
			check_value("response held", 1'b1, is_write ? bvalid : rvalid);
		end
		@(posedge clk);
		if (is_write) begin
			bready <= 1'b1;
		end else begin
			rready <= 1'b1;
		end
		@(posedge clk);
		bready <= 1'b0;
		rready <= 1'b0;
		@(negedge clk);
		check_value("single response", 1'b0, bvalid | rvalid);
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		@(posedge clk);
		awvalid <= 1'b1;
		awaddr  <= addr;
		wvalid  <= 1'b1;
		wdata   <= data;
		wstrb   <= strb;
		do @(negedge clk); while (!(awready && wready));
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		take_response(1'b1);
		resp = bresp;
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clk);
		arvalid <= 1'b1;
		araddr  <= addr;
		do @(negedge clk); while (!arready);
		@(posedge clk);
		arvalid <= 1'b0;
		take_response(1'b0);
		data = rdata;
		resp = rresp;
	endtask

	task automatic read_rx_check(input string name);
		logic [31:0] data;
		logic [1:0]  resp;
		logic [7:0]  exp_byte;
		exp_byte = 8'h00;
		if (rx_model.size() != 0) begin
			exp_byte = rx_model.pop_front();
		end
		read_reg(REG_RXDATA, data, resp);
		check_value({name, " resp"}, RESP_OKAY, resp);
		check_value(name, {24'h0, exp_byte}, data);
	endtask

	task automatic check_status(input string name);
		logic [31:0] data;
		logic [1:0]  resp;
		read_reg(REG_STATUS, data, resp);
		check_value({name, " resp"}, RESP_OKAY, resp);
		check_value(name, expected_status(), data);
	endtask

	task automatic clear_status();
		logic [1:0] resp;
		write_reg(REG_STATUS, 32'h0, 4'hF, resp);
		check_value("status clear resp", RESP_OKAY, resp);
		overrun_flag = 1'b0;
		frame_flag   = 1'b0;
	endtask

	// lsb first and one idle bit after the stop bit
	task automatic send_serial(input logic [7:0] data, input logic stop_bit);
		@(posedge clk);
		uart_rx <= 1'b0;
		repeat (BIT_CYCLES) @(posedge clk);
		for (int i = 0; i < 8; i++) begin
			uart_rx <= data[i];
			repeat (BIT_CYCLES) @(posedge clk);
		end
		uart_rx <= stop_bit;
		repeat (BIT_CYCLES) @(posedge clk);
		uart_rx <= 1'b1;
		repeat (BIT_CYCLES) @(posedge clk);
		if (!stop_bit) begin
			frame_flag = 1'b1;
		end else if (rx_model.size() < RX_DEPTH) begin
			rx_model.push_back(data);
		end else begin
			overrun_flag = 1'b1;
		end
	endtask

	task automatic wait_tx_drain(input string name);
		while (tx_seen.size() < tx_expect.size()) begin
			@(negedge clk);
		end
		foreach (tx_expect[i]) begin
			check_value($sformatf("%s byte %0d", name, i), tx_expect[i], tx_seen[i]);
		end
		tx_expect.delete();
		tx_seen.delete();
	endtask

	task automatic start_test();
		test_err_start = total_errors();
	endtask

	task automatic finish_test(input string name);
		int errs;
		errs = total_errors() - test_err_start;
		test_count++;
		if (errs != 0) begin
			test_fail++;
		end
		$display("test %0d %-16s %s (%0d errors)", test_count, name,
			(errs == 0) ? "pass" : "fail", errs);
	endtask

	// serial line decoder sampling near the middle of each bit
	initial begin : tx_monitor
		logic [7:0] shift;
		forever begin
			@(negedge clk);
			if (!rst && !uart_tx) begin
				repeat (BIT_CYCLES / 2 - 1) @(negedge clk);
				check_value("tx start bit", 1'b0, uart_tx);
				for (int i = 0; i < 8; i++) begin
					repeat (BIT_CYCLES) @(negedge clk);
					shift[i] = uart_tx;
				end
				repeat (BIT_CYCLES) @(negedge clk);
				check_value("tx stop bit", 1'b1, uart_tx);
				tx_seen.push_back(shift);
			end
		end
	end

	initial begin : watchdog
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
		$display("Done: errors found");
		$finish;
	end

	initial begin : stimulus
		logic [1:0]  resp;
		logic [31:0] data;
		logic [7:0]  byte_val;
		int          op;
		rst      <= 1'b1;
		awvalid  <= 1'b0;
		awaddr   <= '0;
		wvalid   <= 1'b0;
		wdata    <= '0;
		wstrb    <= '0;
		bready   <= 1'b0;
		arvalid  <= 1'b0;
		araddr   <= '0;
		rready   <= 1'b0;
		uart_rx  <= 1'b1;
		uart_cts <= 1'b0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		repeat (2) @(posedge clk);
		check_value("rts tied low", 1'b0, uart_rts);

		// two bursts of ten that each fit the fifo
		start_test();
		for (int burst = 0; burst < 2; burst++) begin
			for (int i = 0; i < 10; i++) begin
				byte_val = 8'($random(seed));
				write_reg(REG_TXDATA, {24'h0, byte_val}, 4'hF, resp);
				check_value("txdata write resp", RESP_OKAY, resp);
				tx_expect.push_back(byte_val);
			end
			wait_tx_drain("tx order");
		end
		finish_test("tx order");

		start_test();
		for (int i = 0; i < RX_DEPTH; i++) begin
			send_serial(8'($random(seed)), 1'b1);
		end
		for (int i = 0; i < RX_DEPTH; i++) begin
			read_rx_check("rx order");
		end
		read_rx_check("rx empty read");
		finish_test("rx order");

		start_test();
		for (int i = 0; i < RX_DEPTH + 2; i++) begin
			send_serial(8'($random(seed)), 1'b1);
		end
		check_status("overrun status");
		// no byte enable so the flags stay
		write_reg(REG_STATUS, 32'h0, 4'h0, resp);
		check_value("status nobe resp", RESP_OKAY, resp);
		check_status("overrun kept");
		for (int i = 0; i < RX_DEPTH; i++) begin
			read_rx_check("overrun data");
		end
		clear_status();
		check_status("overrun cleared");
		finish_test("rx overrun");

		start_test();
		send_serial(8'($random(seed)), 1'b0);
		check_status("frame status");
		read_rx_check("frame no data");
		clear_status();
		send_serial(8'($random(seed)), 1'b1);
		read_rx_check("after frame");
		check_status("frame cleared");
		finish_test("rx framing");

		start_test();
		write_reg(REG_RSVD, 32'h0, 4'hF, resp);
		check_value("rsvd write resp", RESP_SLVERR, resp);
		read_reg(REG_RSVD, data, resp);
		check_value("rsvd read resp", RESP_SLVERR, resp);
		bp_enable = 1'b0;
		for (int i = 0; i < TX_DEPTH + 2; i++) begin
			byte_val = 8'($random(seed));
			write_reg(REG_TXDATA, {24'h0, byte_val}, 4'hF, resp);
			// one byte in the transmitter plus a full fifo
			if (i <= TX_DEPTH) begin
				check_value("fill write resp", RESP_OKAY, resp);
				tx_expect.push_back(byte_val);
			end else begin
				check_value("full write resp", RESP_SLVERR, resp);
			end
		end
		bp_enable = 1'b1;
		wait_tx_drain("fill order");
		check_status("status after fill");
		finish_test("responses");

		start_test();
		for (int i = 0; i < 16; i++) begin
			op = $unsigned($random(seed)) % 3;
			case (op)
				0: check_status("bp status");
				1: read_rx_check("bp rxdata");
				default: clear_status();
			endcase
		end
		finish_test("back-pressure");

		$display("tests: %0d run, %0d failed, %0d errors", test_count, test_fail,
			total_errors());
		if (total_errors() == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* uart_axil.sv */
`timescale 1ns/1ps

module uart_axil #(
	parameter real CLK_FREQ = 5e7,
	parameter real UART_BPS = 9600
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            awvalid_i,
	output logic                            awready_o,
	input  logic [uart_pkg::ADDR_WIDTH-1:0] awaddr_i,
	input  logic                            wvalid_i,
	output logic                            wready_o,
	input  logic [31:0]                     wdata_i,
	input  logic [3:0]                      wstrb_i,
	output logic                            bvalid_o,
	input  logic                            bready_i,
	output logic [1:0]                      bresp_o,
	input  logic                            arvalid_i,
	output logic                            arready_o,
	input  logic [uart_pkg::ADDR_WIDTH-1:0] araddr_i,
	output logic                            rvalid_o,
	input  logic                            rready_i,
	output logic [31:0]                     rdata_o,
	output logic [1:0]                      rresp_o,
	input  logic                            uart_rx_i,
	input  logic                            uart_cts_i,
	output logic                            uart_tx_o,
	output logic                            uart_rts_o
);
	import uart_pkg::*;

	localparam int CLKS_PER_BIT = int'(CLK_FREQ / UART_BPS);

	logic                  req_valid;
	logic                  req_wr;
	logic [ADDR_WIDTH-1:0] req_addr;
	logic [31:0]           req_wdata;
	logic [3:0]            req_be;
	logic                  rsp_done;
	logic [31:0]           rsp_rdata;
	logic                  rsp_err;
	reg_addr_e             req_reg;
	logic                  wr_ok;
	logic                  stat_clr;
	logic                  rd_rx_q;
	logic                  rd_stat_q;
	logic [31:0]           status;
	logic                  overrun_q;
	logic                  frame_q;
	logic                  tx_wr_en;
	logic                  tx_rd_en;
	logic                  tx_empty;
	logic                  tx_full;
	logic [7:0]            tx_rd_data;
	logic                  rx_wr_en;
	logic                  rx_rd_en;
	logic                  rx_empty;
	logic                  rx_full;
	logic [7:0]            rx_rd_data;
	logic                  tx_send;
	logic                  tx_busy;
	logic                  tx_done;
	logic [7:0]            rx_data;
	logic                  rx_done;
	logic                  rx_frame_err;
	feed_state_e           feed_state;
	feed_state_e           feed_next;

	// no flow control, cts is not looked at
	assign uart_rts_o = 1'b0;

	axil_bridge u_bridge (
		.clk         (clk),
		.rst         (rst),
		.awvalid_i   (awvalid_i),
		.awready_o   (awready_o),
		.awaddr_i    (awaddr_i),
		.wvalid_i    (wvalid_i),
		.wready_o    (wready_o),
		.wdata_i     (wdata_i),
		.wstrb_i     (wstrb_i),
		.bvalid_o    (bvalid_o),
		.bready_i    (bready_i),
		.bresp_o     (bresp_o),
		.arvalid_i   (arvalid_i),
		.arready_o   (arready_o),
		.araddr_i    (araddr_i),
		.rvalid_o    (rvalid_o),
		.rready_i    (rready_i),
		.rdata_o     (rdata_o),
		.rresp_o     (rresp_o),
		.req_valid_o (req_valid),
		.req_wr_o    (req_wr),
		.req_addr_o  (req_addr),
		.req_wdata_o (req_wdata),
		.req_be_o    (req_be),
		.rsp_done_i  (rsp_done),
		.rsp_rdata_i (rsp_rdata),
		.rsp_err_i   (rsp_err)
	);

	// register decode, word aligned
	assign req_reg  = reg_addr_e'({req_addr[ADDR_WIDTH-1:2], 2'b00});
	assign wr_ok    = req_valid && req_wr && req_be[0];
	assign tx_wr_en = wr_ok && (req_reg == REG_TXDATA) && !tx_full;
	assign stat_clr = wr_ok && (req_reg == REG_STATUS);
	assign rx_rd_en = req_valid && !req_wr && (req_reg == REG_RXDATA) && !rx_empty;
	assign rx_wr_en = rx_done && !rx_full;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rsp_done  <= 1'b0;
			rsp_err   <= 1'b0;
			rd_rx_q   <= 1'b0;
			rd_stat_q <= 1'b0;
		end else begin
			rsp_done  <= req_valid;
			rsp_err   <= req_valid && ((req_reg == REG_RSVD) ||
				(wr_ok && (req_reg == REG_TXDATA) && tx_full));
			rd_rx_q   <= rx_rd_en;
			rd_stat_q <= req_valid && !req_wr && (req_reg == REG_STATUS);
		end
	end

	always_comb begin
		status                  = '0;
		status[STAT_TX_FULL]    = tx_full;
		status[STAT_TX_EMPTY]   = tx_empty;
		status[STAT_RX_VALID]   = !rx_empty;
		status[STAT_RX_OVERRUN] = overrun_q;
		status[STAT_RX_FRAME]   = frame_q;
	end

	// empty rxdata read falls through to zero
	always_comb begin
		rsp_rdata = '0;
		if (rd_rx_q) begin
			rsp_rdata = {24'b0, rx_rd_data};
		end else if (rd_stat_q) begin
			rsp_rdata = status;
		end
	end

	// sticky flags, a new event wins over a clear
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			overrun_q <= 1'b0;
			frame_q   <= 1'b0;
		end else begin
			if (rx_done && rx_full) begin
				overrun_q <= 1'b1;
			end else if (stat_clr) begin
				overrun_q <= 1'b0;
			end
			if (rx_frame_err) begin
				frame_q <= 1'b1;
			end else if (stat_clr) begin
				frame_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			feed_state <= FEED_IDLE;
		end else begin
			feed_state <= feed_next;
		end
	end

	// pop, then send once the fifo data is out
	always_comb begin
		feed_next = feed_state;
		tx_rd_en  = 1'b0;
		tx_send   = 1'b0;
		case (feed_state)
			FEED_IDLE: begin
				if (!tx_empty && !tx_busy) begin
					tx_rd_en  = 1'b1;
					feed_next = FEED_LOAD;
				end
			end
			FEED_LOAD: begin
				tx_send   = 1'b1;
				feed_next = FEED_SEND;
			end
			FEED_SEND: begin
				if (tx_done) begin
					feed_next = FEED_IDLE;
				end
			end
			default: feed_next = FEED_IDLE;
		endcase
	end

	sync_fifo #(
		.DEPTH_LOG2 (TX_FIFO_AW)
	) u_tx_fifo (
		.clk       (clk),
		.rst       (rst),
		.wr_en_i   (tx_wr_en),
		.wr_data_i (req_wdata[7:0]),
		.rd_en_i   (tx_rd_en),
		.rd_data_o (tx_rd_data),
		.empty_o   (tx_empty),
		.full_o    (tx_full),
		.count_o   ()
	);

	sync_fifo #(
		.DEPTH_LOG2 (RX_FIFO_AW)
	) u_rx_fifo (
		.clk       (clk),
		.rst       (rst),
		.wr_en_i   (rx_wr_en),
		.wr_data_i (rx_data),
		.rd_en_i   (rx_rd_en),
		.rd_data_o (rx_rd_data),
		.empty_o   (rx_empty),
		.full_o    (rx_full),
		.count_o   ()
	);

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_tx (
		.clk    (clk),
		.rst    (rst),
		.send_i (tx_send),
		.data_i (tx_rd_data),
		.tx_o   (uart_tx_o),
		.busy_o (tx_busy),
		.done_o (tx_done)
	);

	uart_rx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_rx (
		.clk         (clk),
		.rst         (rst),
		.rx_i        (uart_rx_i),
		.data_o      (rx_data),
		.done_o      (rx_done),
		.frame_err_o (rx_frame_err)
	);

endmodule

/* uart_axil_properties.sv */
`timescale 1ns/1ps

module uart_axil_properties (
	input logic        clk,
	input logic        rst,
	input logic        awvalid_i,
	input logic        awready_i,
	input logic        arvalid_i,
	input logic        arready_i,
	input logic        bvalid_i,
	input logic        bready_i,
	input logic [1:0]  bresp_i,
	input logic        rvalid_i,
	input logic        rready_i,
	input logic [31:0] rdata_i,
	input logic [1:0]  rresp_i,
	input logic        tx_rd_en_i,
	input logic        tx_full_i,
	input logic        rx_rd_en_i,
	input logic        rx_full_i
);

	int fail_cnt = 0;

	// response and its payload hold until ready
	a_b_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
	else begin
		$error("bvalid dropped or bresp changed before bready");
		fail_cnt++;
	end

	a_r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
	else begin
		$error("rvalid dropped or read payload changed before rready");
		fail_cnt++;
	end

	// fixed latency from address handshake to response
	a_b_latency: assert property (@(posedge clk) disable iff (rst)
		awvalid_i && awready_i |-> ##3 $rose(bvalid_i))
	else begin
		$error("bvalid did not rise 3 cycles after the write address handshake");
		fail_cnt++;
	end

	a_r_latency: assert property (@(posedge clk) disable iff (rst)
		arvalid_i && arready_i |-> ##3 $rose(rvalid_i))
	else begin
		$error("rvalid did not rise 3 cycles after the read address handshake");
		fail_cnt++;
	end

	a_no_accept: assert property (@(posedge clk) disable iff (rst)
		bvalid_i || rvalid_i |-> !awready_i && !arready_i)
	else begin
		$error("address accepted while a response is pending");
		fail_cnt++;
	end

	// a full fifo stays full until it is popped
	a_tx_full: assert property (@(posedge clk) disable iff (rst)
		tx_full_i && !tx_rd_en_i |=> tx_full_i)
	else begin
		$error("transmit fifo left full without a pop");
		fail_cnt++;
	end

	a_rx_full: assert property (@(posedge clk) disable iff (rst)
		rx_full_i && !rx_rd_en_i |=> rx_full_i)
	else begin
		$error("receive fifo left full without a pop");
		fail_cnt++;
	end

endmodule

bind uart_axil uart_axil_properties u_props (
	.clk        (clk),
	.rst        (rst),
	.awvalid_i  (awvalid_i),
	.awready_i  (awready_o),
	.arvalid_i  (arvalid_i),
	.arready_i  (arready_o),
	.bvalid_i   (bvalid_o),
	.bready_i   (bready_i),
	.bresp_i    (bresp_o),
	.rvalid_i   (rvalid_o),
	.rready_i   (rready_i),
	.rdata_i    (rdata_o),
	.rresp_i    (rresp_o),
	.tx_rd_en_i (tx_rd_en),
	.tx_full_i  (tx_full),
	.rx_rd_en_i (rx_rd_en),
	.rx_full_i  (rx_full)
);

/* uart_pkg.sv */
package uart_pkg;

	localparam int ADDR_WIDTH = 4;

	// word registers, decoded on the aligned offset
	typedef enum logic [ADDR_WIDTH-1:0] {
		REG_TXDATA = 4'h0,
		REG_RXDATA = 4'h4,
		REG_STATUS = 4'h8,
		REG_RSVD   = 4'hC
	} reg_addr_e;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// status word bits
	localparam int STAT_TX_FULL    = 0;
	localparam int STAT_TX_EMPTY   = 1;
	localparam int STAT_RX_VALID   = 2;
	localparam int STAT_RX_OVERRUN = 3;
	localparam int STAT_RX_FRAME   = 4;

	// log2 of fifo depth
	localparam int TX_FIFO_AW = 4;
	localparam int RX_FIFO_AW = 2;

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		RESP
	} bridge_state_e;

	typedef enum logic [1:0] {
		FEED_IDLE,
		FEED_LOAD,
		FEED_SEND
	} feed_state_e;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

endpackage

/* uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       rx_i,
	output logic [7:0] data_o,
	output logic       done_o,
	output logic       frame_err_o
);
	import uart_pkg::*;

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);

	rx_state_e        state;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift_q;
	logic             rx_meta;
	logic             rx_sync;
	logic             rx_prev;
	logic             bit_last;

	assign bit_last = (clk_cnt == CNT_LAST);

	// two-flop synchronizer plus one more for edge detect
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx_i;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_last) begin
			shift_q <= {rx_sync, shift_q[7:1]};
		end
		if (state == RX_STOP && bit_last && rx_sync) begin
			data_o <= shift_q;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state       <= RX_IDLE;
			clk_cnt     <= '0;
			bit_idx     <= '0;
			done_o      <= 1'b0;
			frame_err_o <= 1'b0;
		end else begin
			done_o      <= 1'b0;
			frame_err_o <= 1'b0;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					// only a falling edge starts a frame, so a stuck-low line is ignored
					if (rx_prev && !rx_sync) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					if (clk_cnt == CNT_HALF) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// glitch, back to idle
						state   <= rx_sync ? RX_IDLE : RX_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (bit_last) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state <= RX_STOP;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (bit_last) begin
						clk_cnt     <= '0;
						done_o      <= rx_sync;
						frame_err_o <= !rx_sync;
						state       <= RX_IDLE;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       send_i,
	input  logic [7:0] data_i,
	output logic       tx_o,
	output logic       busy_o,
	output logic       done_o
);
	import uart_pkg::*;

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

	tx_state_e        state;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       data_q;
	logic             bit_end;

	assign bit_end = (clk_cnt == CNT_LAST);
	assign busy_o  = (state != TX_IDLE);

	always_ff @(posedge clk) begin
		if (state == TX_IDLE && send_i) begin
			data_q <= data_i;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state   <= TX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			tx_o    <= 1'b1;
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (state == TX_IDLE || bit_end) begin
				clk_cnt <= '0;
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
			case (state)
				TX_IDLE: begin
					if (send_i) begin
						tx_o  <= 1'b0;
						state <= TX_START;
					end
				end
				TX_START: begin
					if (bit_end) begin
						tx_o    <= data_q[0];
						bit_idx <= '0;
						state   <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						if (bit_idx == 3'd7) begin
							tx_o  <= 1'b1;
							state <= TX_STOP;
						end else begin
							// lsb first
							tx_o    <= data_q[bit_idx + 3'd1];
							bit_idx <= bit_idx + 3'd1;
						end
					end
				end
				TX_STOP: begin
					if (bit_end) begin
						done_o <= 1'b1;
						state  <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule
